//--- design/bus_pkg.sv
`default_nettype none

package bus_pkg;

   // Bus dimensions
   localparam int num_masters = 6;
   localparam int addr_w      = 16;
   localparam int data_w      = 32;

   // Requester slots on br/bg
   localparam int m_icache = 0;
   localparam int m_dcache = 1;
   localparam int m_mem    = 2;
   localparam int m_kbd    = 3;
   localparam int m_dma    = 4;
   localparam int m_spare  = 5;

   // Grant priority, highest first
   localparam int prio_order [num_masters] = '{
      m_mem,
      m_dcache,
      m_icache,
      m_kbd,
      m_dma,
      m_spare
   };

   // Addresses from here up belong to the I/O block
   localparam logic [addr_w-1:0] io_base = 16'hf000;

   // Command encoding on bus_write
   localparam logic cmd_write = 1'b1;
   localparam logic cmd_read  = 1'b0;

endpackage

`default_nettype wire

//--- design/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter
   import bus_pkg::*;
(
   input  wire logic                   bus_clk,
   input  wire logic                   rst,
   input  wire logic [num_masters-1:0] br,
   input  wire logic                   mem_ack,
   input  wire logic                   io_ack,
   output logic      [num_masters-1:0] bg,
   output logic                        bus_ack
);

   localparam logic st_idle = 1'b0;
   localparam logic st_busy = 1'b1;

   logic                   state;
   logic                   any_req;
   logic                   idle_to_busy;
   logic                   busy_to_idle;
   logic [num_masters-1:0] pick;

   // One acknowledge for the whole bus, whichever slave answered
   assign bus_ack = mem_ack | io_ack;

   assign any_req = |br;

   // Priority picker
   // Walk from lowest to highest priority so the strongest requester wins
   always_comb begin
      pick = '0;
      for (int i = num_masters - 1; i >= 0; i--) begin
         if (br[prio_order[i]]) begin
            pick = '0;
            pick[prio_order[i]] = 1'b1;
         end
      end
   end

   assign idle_to_busy = (state == st_idle) && any_req;
   assign busy_to_idle = (state == st_busy) && bus_ack;

   // Idle/busy state
   always_ff @(posedge bus_clk) begin
      if (rst) begin
         state <= st_idle;
      end else if (idle_to_busy) begin
         state <= st_busy;
      end else if (busy_to_idle) begin
         state <= st_idle;
      end
   end

   // Grant register
   // Loaded only when leaving idle, so later requests cannot steal the bus
   always_ff @(posedge bus_clk) begin
      if (rst) begin
         bg <= '0;
      end else if (idle_to_busy) begin
         bg <= pick;
      end else if (busy_to_idle) begin
         bg <= '0;
      end
   end

endmodule

`default_nettype wire

//--- design/bus_master_mux.sv
`timescale 1ns/1ps
`default_nettype none

module bus_master_mux
   import bus_pkg::*;
(
   input  wire logic [num_masters-1:0]             bg,
   input  wire logic [num_masters-1:0][addr_w-1:0] m_addr,
   input  wire logic [num_masters-1:0][data_w-1:0] m_wdata,
   input  wire logic [num_masters-1:0]             m_write,
   input  wire logic [data_w-1:0]                  mem_rdata,
   input  wire logic [data_w-1:0]                  io_rdata,
   output logic                                    bus_valid,
   output logic      [addr_w-1:0]                  bus_addr,
   output logic      [data_w-1:0]                  bus_wdata,
   output logic                                    bus_write,
   output logic                                    sel_mem,
   output logic                                    sel_io,
   output logic      [data_w-1:0]                  bus_rdata
);

   logic in_io_space;

   assign bus_valid = |bg;

   // AND-OR select on the one-hot grant
   always_comb begin
      bus_addr  = '0;
      bus_wdata = '0;
      bus_write = cmd_read;
      for (int i = 0; i < num_masters; i++) begin
         if (bg[i]) begin
            bus_addr  = bus_addr | m_addr[i];
            bus_wdata = bus_wdata | m_wdata[i];
            bus_write = bus_write | m_write[i];
         end
      end
   end

   // Slave decode
   assign in_io_space = (bus_addr >= io_base);
   assign sel_io      = bus_valid && in_io_space;
   assign sel_mem     = bus_valid && !in_io_space;

   // Read data follows the decoded slave
   assign bus_rdata = in_io_space ? io_rdata : mem_rdata;

endmodule

`default_nettype wire

//--- design/bus_memory.sv
`timescale 1ns/1ps
`default_nettype none

module bus_memory
   import bus_pkg::*;
#(
   parameter int mem_wait  = 2,
   parameter int mem_depth = 256
) (
   input  wire logic              bus_clk,
   input  wire logic              rst,
   input  wire logic              bus_valid,
   input  wire logic              sel_mem,
   input  wire logic [addr_w-1:0] bus_addr,
   input  wire logic [data_w-1:0] bus_wdata,
   input  wire logic              bus_write,
   output logic                   mem_ack,
   output logic      [data_w-1:0] mem_rdata
);

   localparam int idx_w = $clog2(mem_depth);
   // Counter needs at least one bit even with no wait states
   localparam int cnt_w = (mem_wait > 0) ? $clog2(mem_wait + 1) : 1;

   localparam logic [1:0] st_idle = 2'd0;
   localparam logic [1:0] st_wait = 2'd1;
   localparam logic [1:0] st_done = 2'd2;

   logic [data_w-1:0] mem [mem_depth];
   logic [1:0]        state;
   logic [cnt_w-1:0]  wait_cnt;
   logic [idx_w-1:0]  idx;
   logic              start;
   logic              fire;

   // Low address bits wrap over the array
   assign idx = bus_addr[idx_w-1:0];

   assign start = (state == st_idle) && bus_valid && sel_mem;
   assign fire  = (state == st_wait) && (wait_cnt == '0);

   // Wait-state sequencer
   always_ff @(posedge bus_clk) begin
      if (rst) begin
         state    <= st_idle;
         wait_cnt <= '0;
         mem_ack  <= 1'b0;
      end else begin
         mem_ack <= 1'b0;
         case (state)
            st_idle: begin
               if (start) begin
                  wait_cnt <= cnt_w'(mem_wait);
                  state    <= st_wait;
               end
            end
            st_wait: begin
               if (fire) begin
                  mem_ack <= 1'b1;
                  state   <= st_done;
               end else begin
                  wait_cnt <= wait_cnt - 1'b1;
               end
            end
            st_done: begin
               // Hold off until the master lets go of the bus
               if (!bus_valid) begin
                  state <= st_idle;
               end
            end
            default: begin
               state <= st_idle;
            end
         endcase
      end
   end

   // Array access lands on the edge that raises the ack
   always_ff @(posedge bus_clk) begin
      if (fire) begin
         if (bus_write == cmd_write) begin
            mem[idx] <= bus_wdata;
         end else begin
            mem_rdata <= mem[idx];
         end
      end
   end

endmodule

`default_nettype wire

//--- design/bus_io_regs.sv
`timescale 1ns/1ps
`default_nettype none

module bus_io_regs
   import bus_pkg::*;
(
   input  wire logic              bus_clk,
   input  wire logic              rst,
   input  wire logic              bus_valid,
   input  wire logic              sel_io,
   input  wire logic [addr_w-1:0] bus_addr,
   input  wire logic [data_w-1:0] bus_wdata,
   input  wire logic              bus_write,
   output logic                   io_ack,
   output logic      [data_w-1:0] io_rdata
);

   logic [data_w-1:0] regs [8];
   logic [2:0]        idx;
   logic              seen;
   logic              done;
   logic              fire;

   assign idx  = bus_addr[2:0];
   assign fire = seen && !done;

   // Request seen on one edge, answered on the next
   always_ff @(posedge bus_clk) begin
      if (rst) begin
         seen   <= 1'b0;
         done   <= 1'b0;
         io_ack <= 1'b0;
      end else begin
         io_ack <= 1'b0;
         if (fire) begin
            io_ack <= 1'b1;
            seen   <= 1'b0;
            done   <= 1'b1;
         end else if (done) begin
            // Re-arm once the bus goes idle
            if (!bus_valid) begin
               done <= 1'b0;
            end
         end else if (bus_valid && sel_io) begin
            seen <= 1'b1;
         end
      end
   end

   // Register file
   always_ff @(posedge bus_clk) begin
      if (rst) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (fire && (bus_write == cmd_write)) begin
         regs[idx] <= bus_wdata;
      end
   end

   always_ff @(posedge bus_clk) begin
      if (fire && (bus_write == cmd_read)) begin
         io_rdata <= regs[idx];
      end
   end

endmodule

`default_nettype wire

//--- design/sys_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module sys_bus_top
   import bus_pkg::*;
#(
   parameter int mem_wait  = 2,
   parameter int mem_depth = 256
) (
   input  wire logic                                bus_clk,
   input  wire logic                                rst,
   input  wire logic [num_masters-1:0]              br,
   input  wire logic [num_masters-1:0][addr_w-1:0]  m_addr,
   input  wire logic [num_masters-1:0][data_w-1:0]  m_wdata,
   input  wire logic [num_masters-1:0]              m_write,
   output logic      [num_masters-1:0]              bg,
   output logic                                     bus_ack,
   output logic      [data_w-1:0]                   bus_rdata
);

   logic              mem_ack;
   logic              io_ack;
   logic              bus_valid;
   logic [addr_w-1:0] bus_addr;
   logic [data_w-1:0] bus_wdata;
   logic              bus_write;
   logic              sel_mem;
   logic              sel_io;
   logic [data_w-1:0] mem_rdata;
   logic [data_w-1:0] io_rdata;

   bus_arbiter arb0 (
      .bus_clk (bus_clk),
      .rst     (rst),
      .br      (br),
      .mem_ack (mem_ack),
      .io_ack  (io_ack),
      .bg      (bg),
      .bus_ack (bus_ack)
   );

   bus_master_mux mux0 (
      .bg        (bg),
      .m_addr    (m_addr),
      .m_wdata   (m_wdata),
      .m_write   (m_write),
      .mem_rdata (mem_rdata),
      .io_rdata  (io_rdata),
      .bus_valid (bus_valid),
      .bus_addr  (bus_addr),
      .bus_wdata (bus_wdata),
      .bus_write (bus_write),
      .sel_mem   (sel_mem),
      .sel_io    (sel_io),
      .bus_rdata (bus_rdata)
   );

   bus_memory #(
      .mem_wait  (mem_wait),
      .mem_depth (mem_depth)
   ) mem0 (
      .bus_clk   (bus_clk),
      .rst       (rst),
      .bus_valid (bus_valid),
      .sel_mem   (sel_mem),
      .bus_addr  (bus_addr),
      .bus_wdata (bus_wdata),
      .bus_write (bus_write),
      .mem_ack   (mem_ack),
      .mem_rdata (mem_rdata)
   );

   bus_io_regs io0 (
      .bus_clk   (bus_clk),
      .rst       (rst),
      .bus_valid (bus_valid),
      .sel_io    (sel_io),
      .bus_addr  (bus_addr),
      .bus_wdata (bus_wdata),
      .bus_write (bus_write),
      .io_ack    (io_ack),
      .io_rdata  (io_rdata)
   );

endmodule

`default_nettype wire

//--- verif/sys_bus_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sys_bus_tb
   import bus_pkg::*;
();

   localparam int mem_wait   = 2;
   localparam int mem_depth  = 256;
   localparam int idx_w      = $clog2(mem_depth);
   // About 200 transfers of up to mem_wait + 4 cycles, three times over plus settling
   localparam int max_xfers  = 200;
   localparam int max_cycles = max_xfers * (mem_wait + 4) * 3 + 400;

   logic                               bus_clk;
   logic                               rst;
   logic [num_masters-1:0]             br;
   logic [num_masters-1:0][addr_w-1:0] m_addr;
   logic [num_masters-1:0][data_w-1:0] m_wdata;
   logic [num_masters-1:0]             m_write;
   logic [num_masters-1:0]             bg;
   logic                               bus_ack;
   logic [data_w-1:0]                  bus_rdata;

   // Reference model of both slaves
   logic [data_w-1:0] mem_model [mem_depth];
   logic [data_w-1:0] io_model  [8];

   logic [31:0] lfsr;
   int          cycle_cnt;
   int          grant_wait;
   int          ack_wait;

   sys_bus_top #(
      .mem_wait  (mem_wait),
      .mem_depth (mem_depth)
   ) dut0 (
      .bus_clk   (bus_clk),
      .rst       (rst),
      .br        (br),
      .m_addr    (m_addr),
      .m_wdata   (m_wdata),
      .m_write   (m_write),
      .bg        (bg),
      .bus_ack   (bus_ack),
      .bus_rdata (bus_rdata)
   );

   initial begin
      bus_clk = 1'b0;
      forever #2 bus_clk = ~bus_clk;
   end

   always @(posedge bus_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= max_cycles) begin
         $display("Timeout after %0d cycles, a transfer never completed", cycle_cnt);
         $display("SOME TESTS FAILED");
         $fatal(1);
      end
   end

   task automatic stop_on_error(input string msg);
      $display("ERROR @ %0d ns: %s", $time, msg);
      $display("SOME TESTS FAILED");
      $fatal(1);
   endtask

   // Never more than one master on the bus
   always @(negedge bus_clk) begin
      if (!rst) begin
         assert ($onehot0(bg)) else
            stop_on_error($sformatf("bg = 0b%b holds more than one grant", bg));
      end
   end

   // Taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[30:0], lfsr[0]};
      end
   endtask

   function automatic logic [num_masters-1:0] grant_of(input int m);
      logic [num_masters-1:0] g;
      g = '0;
      g[m] = 1'b1;
      return g;
   endfunction

   function automatic logic [data_w-1:0] expected_read(input logic [addr_w-1:0] addr);
      if (addr >= io_base) begin
         return io_model[addr[2:0]];
      end
      return mem_model[addr[idx_w-1:0]];
   endfunction

   function automatic void update_model(input logic [addr_w-1:0] addr,
                                        input logic [data_w-1:0] data);
      if (addr >= io_base) begin
         io_model[addr[2:0]] = data;
      end else begin
         mem_model[addr[idx_w-1:0]] = data;
      end
   endfunction

   // I/O latches the request one edge after the grant and answers on the next
   function automatic int ack_latency(input logic [addr_w-1:0] addr);
      return (addr >= io_base) ? 2 : mem_wait + 2;
   endfunction

   task automatic load_cmd(input int m, input logic [addr_w-1:0] addr,
                           input logic [data_w-1:0] data, input logic write);
      br[m]      <= 1'b1;
      m_addr[m]  <= addr;
      m_wdata[m] <= data;
      m_write[m] <= write;
   endtask

   task automatic issue(input int m, input logic [addr_w-1:0] addr,
                        input logic [data_w-1:0] data, input logic write);
      @(posedge bus_clk);
      load_cmd(m, addr, data, write);
   endtask

   task automatic wait_grant(input int m, output int cycles);
      cycles = 0;
      do begin
         @(negedge bus_clk);
         cycles++;
      end while (!bg[m]);
   endtask

   task automatic wait_any_grant(output int m);
      m = -1;
      do begin
         @(negedge bus_clk);
      end while (bg == '0);
      for (int i = 0; i < num_masters; i++) begin
         if (bg[i]) begin
            m = i;
         end
      end
   endtask

   // Grant must stay put on the same master until the slave answers
   task automatic wait_ack(input int m, output int cycles);
      cycles = 0;
      do begin
         @(negedge bus_clk);
         cycles++;
         assert (bg == grant_of(m)) else
            stop_on_error($sformatf("bg = 0b%b while master %0d waited for ack", bg, m));
      end while (!bus_ack);
   endtask

   task automatic finish_transfer(input int m, input logic [addr_w-1:0] addr,
                                  input logic [data_w-1:0] data, input logic write,
                                  input bit keep);
      logic [data_w-1:0] exp;
      exp = expected_read(addr);
      if (write == cmd_write) begin
         update_model(addr, data);
      end else begin
         assert (bus_rdata === exp) else
            stop_on_error($sformatf("read 0x%h at 0x%h by master %0d, expected 0x%h",
                                    bus_rdata, addr, m, exp));
      end
      @(posedge bus_clk);
      if (!keep) begin
         br[m] <= 1'b0;
      end
   endtask

   task automatic do_transfer(input int m, input logic [addr_w-1:0] addr,
                              input logic [data_w-1:0] data, input logic write);
      issue(m, addr, data, write);
      // br goes out on one edge, the arbiter grants on the next
      wait_grant(m, grant_wait);
      assert (grant_wait == 2) else
         stop_on_error($sformatf("grant to master %0d took %0d cycles", m, grant_wait - 1));
      wait_ack(m, ack_wait);
      assert (ack_wait == ack_latency(addr)) else
         stop_on_error($sformatf("ack at 0x%h came %0d cycles after grant, expected %0d",
                                 addr, ack_wait, ack_latency(addr)));
      finish_transfer(m, addr, data, write, 1'b0);
   endtask

   task automatic test_reset();
      repeat (8) begin
         @(negedge bus_clk);
         assert (bg == '0 && bus_ack == 1'b0) else
            stop_on_error($sformatf("idle bus shows bg = 0b%b ack = %b", bg, bus_ack));
      end
   endtask

   task automatic test_memory_rw();
      logic [31:0]       r;
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] data;
      for (int m = 0; m < num_masters; m++) begin
         repeat (4) begin
            // 15 bits keep the address below io_base
            rand_bits(15, r);
            addr = r[addr_w-1:0];
            rand_bits(32, r);
            data = r;
            do_transfer(m, addr, data, cmd_write);
            do_transfer(m, addr, '0, cmd_read);
         end
      end
   endtask

   task automatic test_io();
      logic [31:0]       r;
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] data;
      for (int i = 0; i < 8; i++) begin
         rand_bits(12, r);
         addr = io_base | {4'h0, r[11:0]};
         rand_bits(32, r);
         data = r;
         do_transfer(m_kbd, addr, data, cmd_write);
         do_transfer(m_spare, addr, '0, cmd_read);
      end
      // Same low bits in both spaces
      do_transfer(m_dma, 16'h0005, 32'h1111_0005, cmd_write);
      do_transfer(m_dma, io_base | 16'h0005, 32'h2222_0005, cmd_write);
      do_transfer(m_dcache, 16'h0005, '0, cmd_read);
      do_transfer(m_dcache, io_base | 16'h0005, '0, cmd_read);
   endtask

   task automatic test_priority();
      logic [31:0]       r;
      logic [data_w-1:0] data [num_masters];
      int                exp_order [num_masters];
      int                m;
      exp_order = '{m_mem, m_dcache, m_icache, m_kbd, m_dma, m_spare};
      @(posedge bus_clk);
      for (int i = 0; i < num_masters; i++) begin
         rand_bits(32, r);
         data[i] = r;
         load_cmd(i, 16'h0040 + addr_w'(i), data[i], cmd_write);
      end
      for (int k = 0; k < num_masters; k++) begin
         wait_any_grant(m);
         assert (m == exp_order[k]) else
            stop_on_error($sformatf("grant %0d went to master %0d, expected %0d",
                                    k, m, exp_order[k]));
         wait_ack(m, ack_wait);
         finish_transfer(m, 16'h0040 + addr_w'(m), data[m], cmd_write, 1'b0);
      end
      for (int i = 0; i < num_masters; i++) begin
         do_transfer(m_icache, 16'h0040 + addr_w'(i), '0, cmd_read);
      end
   endtask

   task automatic test_backpressure();
      logic [31:0]       r;
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] data;
      rand_bits(15, r);
      addr = r[addr_w-1:0];
      rand_bits(32, r);
      data = r;
      issue(m_icache, addr, data, cmd_write);
      wait_grant(m_icache, grant_wait);
      // Stronger master shows up during the wait states
      issue(m_mem, 16'h0042, '0, cmd_read);
      wait_ack(m_icache, ack_wait);
      finish_transfer(m_icache, addr, data, cmd_write, 1'b0);
      wait_grant(m_mem, grant_wait);
      assert (grant_wait == 2) else
         stop_on_error($sformatf("waiting master granted %0d cycles after release",
                                 grant_wait - 1));
      wait_ack(m_mem, ack_wait);
      finish_transfer(m_mem, 16'h0042, '0, cmd_read, 1'b0);
      do_transfer(m_dma, addr, '0, cmd_read);
   endtask

   task automatic test_back_to_back();
      logic [31:0]       r;
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] data;
      rand_bits(15, r);
      addr = r[addr_w-1:0];
      rand_bits(32, r);
      data = r;
      issue(m_dma, addr, data, cmd_write);
      wait_grant(m_dma, grant_wait);
      wait_ack(m_dma, ack_wait);
      finish_transfer(m_dma, addr, data, cmd_write, 1'b1);
      // br stays high, only the command changes
      load_cmd(m_dma, addr, '0, cmd_read);
      wait_grant(m_dma, grant_wait);
      assert (grant_wait == 2) else
         stop_on_error($sformatf("regrant gap of %0d cycles, expected 1", grant_wait - 1));
      wait_ack(m_dma, ack_wait);
      finish_transfer(m_dma, addr, '0, cmd_read, 1'b0);
   endtask

   initial begin
      rst       = 1'b1;
      br        = '0;
      m_addr    = '0;
      m_wdata   = '0;
      m_write   = '0;
      cycle_cnt = 0;
      lfsr      = 32'hdba18b66;
      io_model  = '{default: '0};
      repeat (5) @(posedge bus_clk);
      rst <= 1'b0;
      test_reset();
      test_memory_rw();
      test_io();
      test_priority();
      test_backpressure();
      test_back_to_back();
      repeat (4) @(posedge bus_clk);
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- tb.f
design/bus_pkg.sv
design/bus_arbiter.sv
design/bus_master_mux.sv
design/bus_memory.sv
design/bus_io_regs.sv
design/sys_bus_top.sv
verif/sys_bus_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the system bus testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
   -f tb.f \
   --top-module sys_bus_tb \
   -o sys_bus_sim

./obj_dir/sys_bus_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed, see sim.log"
   exit 1
fi
